// ==== filelist.f ====
pcie_tlp_pkg.sv
rx_axi_pkg.sv
rx_beat_format.sv
rx_skid_pipeline.sv
rx_msi_detect.sv
rx_pipeline_top.sv
rx_pipeline_chk.sv
tb_rx_pipeline.sv

// ==== Bender.yml ====
package:
  name: rx_pipeline

sources:
  - pcie_tlp_pkg.sv
  - rx_axi_pkg.sv
  - rx_beat_format.sv
  - rx_skid_pipeline.sv
  - rx_msi_detect.sv
  - rx_pipeline_top.sv
  - target: test
    files:
      - rx_pipeline_chk.sv
      - tb_rx_pipeline.sv

// ==== tb_rx_pipeline.sv ====
/*
 * Testbench for the 64-bit TRN to AXI-Stream receive pipeline
 * Random packets with source gaps and tready throttling. A queue of
 * expected beats checks every AXI transfer, a small model checks the
 * MSI flag in every cycle.
 */

`timescale 1ns/1ns
`default_nettype none

module tb_rx_pipeline
  import rx_axi_pkg::*, pcie_tlp_pkg::*;
;

  localparam logic [63:0] msi_addr = 64'h0000_0000_fee0_1000;  // 3DW and 4DW reachable

  logic      com_iclk         = 1'b0;
  logic      com_sysrst       = 1'b1;
  trn_beat_t trn_rd           = '0;
  logic      trn_rsrc_rdy     = 1'b0;
  logic      m_axis_rx_tready = 1'b1;
  logic [63:0] msi_address    = msi_addr;
  logic      trn_rdst_rdy;
  axi_beat_t m_axis_rx;
  logic      m_axis_rx_tvalid;
  logic      is_msi_trn;

  trn_beat_t  stim_beat[$];   // One entry per driven cycle
  logic       stim_vld[$];
  axi_beat_t  exp_q[$];       // Expected AXI beats, in order
  int         stim_pos    = 0;
  logic       stim_done   = 1'b0;
  int         free_run    = 0;  // Entries driven with tready stuck high
  int         cycle_limit = 0;
  int         cycles      = 0;
  msi_state_e msi_model   = msi_idle;
  logic       msi_held    = 1'b0;

  always #10 com_iclk = ~com_iclk;

  rx_pipeline_top dut (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .trn_rd           (trn_rd),
    .trn_rsrc_rdy     (trn_rsrc_rdy),
    .trn_rdst_rdy     (trn_rdst_rdy),
    .msi_address      (msi_address),
    .is_msi_trn       (is_msi_trn),
    .m_axis_rx        (m_axis_rx),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tready (m_axis_rx_tready)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  task automatic fail_now();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] want);
    assert (got === want) else begin
      $display("Fail at %0t ns: %s is %h, expected %h", $time, name, got, want);
      fail_now();
    end
  endtask

  task automatic push_beat(input logic vld, input trn_beat_t b);
    stim_vld.push_back(vld);
    stim_beat.push_back(b);
  endtask

  task automatic idle_gap();
    trn_beat_t b;
    b = {$urandom, $urandom, 12'($urandom)};  // Random filler with rsrc low
    push_beat(1'b0, b);
  endtask

  // Kinds 0/1 MWr 3DW hit/miss, 2/3 MWr 4DW hit/miss, 4 non-memory, 5 MRd
  task automatic gen_packet(input int kind);
    trn_beat_t  b;
    int         len;
    logic [1:0] fmt;
    logic [4:0] typ;
    len = (kind < 4) ? $urandom_range(2, 6) : $urandom_range(1, 6);
    case (kind)
      0, 1:    fmt = 2'b10;
      2, 3:    fmt = 2'b11;
      4:       fmt = 2'($urandom_range(0, 3));
      default: fmt = 2'($urandom_range(0, 1));  // No data
    endcase
    typ = (kind == 4) ? 5'($urandom_range(1, 31)) : 5'b00000;
    for (int i = 0; i < len; i++) begin
      repeat (($urandom_range(0, 3) == 0) ? $urandom_range(1, 2) : 0) idle_gap();
      b.data     = {$urandom, $urandom};
      b.sof      = (i == 0);
      b.eof      = (i == len - 1);
      b.rem      = (i == len - 1) ? 1'($urandom_range(0, 1)) : 1'b1;
      b.bar_hit  = 8'($urandom);
      b.errfwd   = ($urandom_range(0, 15) == 0);
      b.ecrc_err = ($urandom_range(0, 15) == 0);
      if (i == 0) begin
        b.data[63:56] = {1'b0, fmt, typ};  // Header DW0 top byte
      end else if (i == 1) begin
        case (kind)
          0: b.data[63:32] = msi_addr[31:0];
          1: b.data[63:32] = msi_addr[31:0] ^ ($urandom | 1);
          2: b.data        = msi_addr;
          3: b.data        = msi_addr ^ {32'($urandom), 32'($urandom | 1)};
          default: ;
        endcase
      end
      push_beat(1'b1, b);
    end
  endtask

  // AXI beat as the formatting rules give it
  function automatic axi_beat_t expect_beat(input trn_beat_t t);
    axi_beat_t e;
    e.data          = {t.data[31:0], t.data[63:32]};  // DW0 to bottom
    e.strb          = t.rem ? 8'hff : 8'h0f;
    e.last          = t.eof;
    e.user.is_eof   = {t.eof, 1'b0, t.rem, 2'b11};
    e.user.rsvd     = 2'b00;
    e.user.is_sof   = {t.sof, 4'b0000};
    e.user.bar_hit  = t.bar_hit;
    e.user.err_fwd  = t.errfwd;
    e.user.ecrc_err = t.ecrc_err;
    return e;
  endfunction

  // ------------------------------------------------------------
  // Drivers
  // ------------------------------------------------------------
  always @(posedge com_iclk) begin
    if (!com_sysrst && (!trn_rsrc_rdy || trn_rdst_rdy)) begin  // Slot free
      if (stim_pos < stim_vld.size()) begin
        trn_rd       <= stim_beat[stim_pos];
        trn_rsrc_rdy <= stim_vld[stim_pos];
        stim_pos     <= stim_pos + 1;
      end else begin
        trn_rsrc_rdy <= 1'b0;
        stim_done    <= 1'b1;
      end
    end
    if (!com_sysrst) begin
      m_axis_rx_tready <= (stim_pos < free_run) || ($urandom_range(0, 9) < 7);
    end
  end

  // ------------------------------------------------------------
  // Scoreboard and MSI model
  // ------------------------------------------------------------
  always @(posedge com_iclk) begin : check_outputs
    axi_beat_t want;
    logic      hit;
    if (!com_sysrst) begin
      cycles++;
      if (cycles > cycle_limit) begin
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        fail_now();
      end
      if (dut.u_chk.err_count != 0) begin
        $display("A protocol assertion in the bound checker failed");
        fail_now();
      end
      if (m_axis_rx_tvalid && m_axis_rx_tready) begin
        if (exp_q.size() == 0) begin
          $display("AXI beat transferred with no TRN beat left to match it");
          fail_now();
        end else begin
          want = exp_q.pop_front();
          check_value("m_axis_rx.data", m_axis_rx.data, want.data);
          check_value("m_axis_rx.strb", m_axis_rx.strb, want.strb);
          check_value("m_axis_rx.last", m_axis_rx.last, want.last);
          check_value("m_axis_rx.user.is_sof", m_axis_rx.user.is_sof, want.user.is_sof);
          check_value("m_axis_rx.user.is_eof", m_axis_rx.user.is_eof, want.user.is_eof);
          check_value("m_axis_rx.user.rsvd", m_axis_rx.user.rsvd, want.user.rsvd);
          check_value("m_axis_rx.user.bar_hit", m_axis_rx.user.bar_hit, want.user.bar_hit);
          check_value("m_axis_rx.user.err_fwd", m_axis_rx.user.err_fwd, want.user.err_fwd);
          check_value("m_axis_rx.user.ecrc_err", m_axis_rx.user.ecrc_err,
                      want.user.ecrc_err);
        end
      end
      hit = 1'b0;
      if (trn_rsrc_rdy && trn_rdst_rdy) begin
        exp_q.push_back(expect_beat(trn_rd));
        if (msi_model == msi_addr32) begin
          hit = (msi_address == {32'h0, trn_rd.data[63:32]});  // Raw DW2
        end else if (msi_model == msi_addr64) begin
          hit = (msi_address == trn_rd.data);
        end
      end
      check_value("is_msi_trn", is_msi_trn, hit || msi_held);
      if (trn_rsrc_rdy && trn_rdst_rdy) begin
        if (msi_model != msi_idle) begin
          msi_model = msi_idle;  // Address beat done
        end else if (trn_rd.sof && trn_rd.data[60:56] == 5'b00000) begin
          if (trn_rd.data[62:61] == 2'b10) begin
            msi_model = msi_addr32;
          end else if (trn_rd.data[62:61] == 2'b11) begin
            msi_model = msi_addr64;
          end
        end
      end
      if (hit) begin
        msi_held = 1'b1;
      end else if (m_axis_rx_tvalid && m_axis_rx_tready && m_axis_rx.last) begin
        msi_held = 1'b0;  // End of flagged packet on AXI
      end
    end
  end

  // ------------------------------------------------------------
  // Sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(32'h2a4d));
    for (int p = 0; p < 80; p++) begin
      gen_packet($urandom_range(0, 5));
    end
    free_run    = stim_vld.size() / 3;  // First third unthrottled
    cycle_limit = 4 * stim_vld.size() + 200;
    repeat (16) @(posedge com_iclk);
    com_sysrst <= 1'b0;
    while (!(stim_done && exp_q.size() == 0)) begin
      @(negedge com_iclk);
    end
    repeat (8) @(posedge com_iclk);  // Catch stray extra beats
    @(negedge com_iclk);
    if (exp_q.size() == 0 && dut.u_chk.err_count == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Run ended with %0d expected beats left and %0d checker failures",
               exp_q.size(), dut.u_chk.err_count);
      fail_now();
    end
  end

endmodule

`default_nettype wire

// ==== rx_pipeline_chk.sv ====
/*
 * Protocol checker for the receive pipeline
 * Bound into the top level. Covers the AXI hold rule, reset and idle
 * destination-ready and the one-cycle latency without throttling.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_pipeline_chk
  import rx_axi_pkg::*, pcie_tlp_pkg::*;
(
  input wire            com_iclk,
  input wire            com_sysrst,
  input wire            trn_rsrc_rdy,
  input wire            trn_rdst_rdy,
  input wire axi_beat_t cur_beat,          // Formatted, before the register
  input wire axi_beat_t m_axis_rx,
  input wire            m_axis_rx_tvalid,
  input wire            m_axis_rx_tready
);

  int unsigned err_count = 0;  // Failed assertions so far

  // ------------------------------------------------------------
  // AXI side
  // ------------------------------------------------------------
  // Stalled beat stays put
  a_hold_stable: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    m_axis_rx_tvalid && !m_axis_rx_tready |=> m_axis_rx_tvalid && $stable(m_axis_rx))
    else begin
      $error("m_axis_rx changed or valid dropped while stalled");
      err_count++;
    end

  a_reset_idle: assert property (@(posedge com_iclk)
    com_sysrst |=> !m_axis_rx_tvalid && !trn_rdst_rdy)
    else begin
      $error("valid or destination-ready high right after reset");
      err_count++;
    end

  // Idle output always reopens TRN
  a_idle_ready: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    !m_axis_rx_tvalid |=> trn_rdst_rdy)
    else begin
      $error("destination-ready low one cycle after idle output");
      err_count++;
    end

  // No stall before or during means straight through
  a_latency: assert property (@(posedge com_iclk) disable iff (com_sysrst)
    $past(m_axis_rx_tready) && m_axis_rx_tready && trn_rsrc_rdy && trn_rdst_rdy
    |=> m_axis_rx_tvalid && m_axis_rx == $past(cur_beat))
    else begin
      $error("TRN beat not on AXI exactly one cycle later");
      err_count++;
    end

endmodule

bind rx_pipeline_top rx_pipeline_chk u_chk (
  .com_iclk         (com_iclk),
  .com_sysrst       (com_sysrst),
  .trn_rsrc_rdy     (trn_rsrc_rdy),
  .trn_rdst_rdy     (trn_rdst_rdy),
  .cur_beat         (cur_beat),
  .m_axis_rx        (m_axis_rx),
  .m_axis_rx_tvalid (m_axis_rx_tvalid),
  .m_axis_rx_tready (m_axis_rx_tready)
);

`default_nettype wire

// ==== rx_pipeline_top.sv ====
/*
 * TRN to AXI-Stream receive pipeline, 64-bit
 * Joins the beat formatter, the registered pipeline stage with its
 * previous-value buffer, and the root port MSI detector.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_pipeline_top
  import rx_axi_pkg::*;
(
  input  wire            com_iclk,
  input  wire            com_sysrst,
  // TRN receive
  input  wire trn_beat_t trn_rd,
  input  wire            trn_rsrc_rdy,
  output logic           trn_rdst_rdy,
  // MSI
  input  wire [63:0]     msi_address,
  output logic           is_msi_trn,
  // AXI-Stream master
  output axi_beat_t      m_axis_rx,
  output logic           m_axis_rx_tvalid,
  input  wire            m_axis_rx_tready
);

  axi_beat_t cur_beat;  // Formatted, not yet registered

  rx_beat_format u_format (
    .trn  (trn_rd),
    .beat (cur_beat)
  );

  rx_skid_pipeline u_pipe (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .cur_beat         (cur_beat),
    .trn_rsrc_rdy     (trn_rsrc_rdy),
    .trn_rdst_rdy     (trn_rdst_rdy),
    .m_axis_rx        (m_axis_rx),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tready (m_axis_rx_tready)
  );

  // Detector sees raw data, before the swap
  rx_msi_detect u_msi (
    .com_iclk         (com_iclk),
    .com_sysrst       (com_sysrst),
    .trn_raw          (trn_rd),
    .trn_rsrc_rdy     (trn_rsrc_rdy),
    .trn_rdst_rdy     (trn_rdst_rdy),
    .msi_address      (msi_address),
    .m_axis_rx_tvalid (m_axis_rx_tvalid),
    .m_axis_rx_tready (m_axis_rx_tready),
    .m_axis_rx_tlast  (m_axis_rx.last),
    .is_msi_trn       (is_msi_trn)
  );

endmodule

`default_nettype wire

// ==== rx_msi_detect.sv ====
/*
 * MSI write detector for root port mode
 * Tracks TRN memory write headers on the raw 64-bit bus and flags the
 * packet whose address equals the MSI address. The flag is raised
 * with the address beat and held until the AXI tlast transfer.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_msi_detect
  import rx_axi_pkg::*, pcie_tlp_pkg::*;
(
  input  wire                  com_iclk,
  input  wire                  com_sysrst,
  input  wire trn_beat_t       trn_raw,           // Unswapped TRN beat
  input  wire                  trn_rsrc_rdy,
  input  wire                  trn_rdst_rdy,
  input  wire [msi_addr_w-1:0] msi_address,
  input  wire                  m_axis_rx_tvalid,
  input  wire                  m_axis_rx_tready,
  input  wire                  m_axis_rx_tlast,
  output logic                 is_msi_trn
);

  msi_state_e state;
  tlp_fmt_e   hdr_fmt;
  tlp_type_e  hdr_type;
  logic       trn_xfer;
  logic       msi_hit;   // Address beat matches, this cycle
  logic       msi_held;  // Remembered until tlast

  assign trn_xfer = trn_rsrc_rdy && trn_rdst_rdy;
  assign hdr_fmt  = tlp_fmt_e'(trn_raw.data[hdr_fmt_lsb +: hdr_fmt_w]);
  assign hdr_type = tlp_type_e'(trn_raw.data[hdr_type_lsb +: hdr_type_w]);

  // ----------------------------------------------------------
  // Header tracking
  // ----------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      state <= msi_idle;
    end else begin
      case (state)
        msi_idle: begin
          if (trn_xfer && trn_raw.sof && hdr_type == type_mem) begin
            if (hdr_fmt == fmt_3dw_data) begin
              state <= msi_addr32;
            end else if (hdr_fmt == fmt_4dw_data) begin
              state <= msi_addr64;
            end
          end
        end
        default: begin
          if (trn_xfer) begin
            state <= msi_idle;  // Address beat consumed
          end
        end
      endcase
    end
  end

  // Compare on the beat after the header
  always_comb begin
    case (state)
      msi_addr32: msi_hit = trn_xfer &&
                            (msi_address == {{dword_w{1'b0}}, trn_raw.data[data_w-1 -: dword_w]});
      msi_addr64: msi_hit = trn_xfer && (msi_address == trn_raw.data);
      default:    msi_hit = 1'b0;
    endcase
  end

  // ----------------------------------------------------------
  // Flag hold until end of packet on AXI
  // ----------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      msi_held <= 1'b0;
    end else if (msi_hit) begin
      msi_held <= 1'b1;
    end else if (m_axis_rx_tvalid && m_axis_rx_tready && m_axis_rx_tlast) begin
      msi_held <= 1'b0;
    end
  end

  assign is_msi_trn = msi_hit || msi_held;

endmodule

`default_nettype wire

// ==== rx_skid_pipeline.sv ====
/*
 * Receive pipeline register with previous-value buffer
 * One registered stage between TRN and AXI. The buffer keeps the last
 * accepted TRN beat so that the beat accepted in the cycle before
 * destination-ready drops is not lost while the user throttles.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_skid_pipeline
  import rx_axi_pkg::*;
(
  input  wire            com_iclk,
  input  wire            com_sysrst,
  input  wire axi_beat_t cur_beat,          // Formatted current TRN beat
  input  wire            trn_rsrc_rdy,
  output logic           trn_rdst_rdy,
  output axi_beat_t      m_axis_rx,
  output logic           m_axis_rx_tvalid,
  input  wire            m_axis_rx_tready
);

  axi_beat_t prev_beat;      // Last beat seen while dst ready high
  logic      prev_rsrc_rdy;  // Whether that beat was a real transfer
  logic      hold;
  logic      data_prev;      // Hold released last cycle

  // ----------------------------------------------------------
  // Previous-value buffer
  // ----------------------------------------------------------
  // A new value sits on the TRN side whenever dst ready is high
  always_ff @(posedge com_iclk) begin
    if (trn_rdst_rdy) begin
      prev_beat <= cur_beat;
    end
  end

  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      prev_rsrc_rdy <= 1'b0;
    end else if (trn_rdst_rdy) begin
      prev_rsrc_rdy <= trn_rsrc_rdy;
    end
  end

  // ----------------------------------------------------------
  // Output stage select
  // ----------------------------------------------------------
  assign hold = m_axis_rx_tvalid && !m_axis_rx_tready;  // User stalled

  // After any stall we are one beat behind TRN
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      data_prev <= 1'b0;
    end else begin
      data_prev <= hold;
    end
  end

  // Three cases: hold, previous, current
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      m_axis_rx        <= '{data: '0, strb: strb_full, last: 1'b0, user: '0};
      m_axis_rx_tvalid <= 1'b0;
    end else if (!hold) begin
      if (data_prev) begin
        m_axis_rx        <= prev_beat;      // Catch up from buffer
        m_axis_rx_tvalid <= prev_rsrc_rdy;
      end else begin
        m_axis_rx        <= cur_beat;       // Straight through
        m_axis_rx_tvalid <= trn_rsrc_rdy && trn_rdst_rdy;
      end
    end
    // Otherwise keep the stalled beat
  end

  // ----------------------------------------------------------
  // Destination ready back to TRN
  // ----------------------------------------------------------
  always_ff @(posedge com_iclk) begin
    if (com_sysrst) begin
      trn_rdst_rdy <= 1'b0;
    end else if (m_axis_rx_tvalid) begin
      trn_rdst_rdy <= m_axis_rx_tready;  // Pass back-pressure through
    end else begin
      // Idle output, never miss the first beat of a packet
      trn_rdst_rdy <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rx_beat_format.sv ====
/*
 * TRN to AXI beat formatter
 * Pure combinational mapping of one TRN receive beat onto one
 * AXI-Stream beat: DWORD swap, rem to byte strobes, SOF/EOF
 * location codes and the user sideband.
 */

`timescale 1ns/1ns
`default_nettype none

module rx_beat_format
  import rx_axi_pkg::*;
(
  input  wire trn_beat_t trn,   // Raw TRN beat
  output axi_beat_t      beat   // Same beat, AXI layout
);

  always_comb begin
    // ----------------------------------------------------------
    // Data and strobes
    // ----------------------------------------------------------
    // TRN DW0 sits in the top dword, AXI wants it at the bottom
    beat.data = {trn.data[dword_w-1:0], trn.data[data_w-1:dword_w]};

    // Only two legal EOF positions on a 64-bit bus
    beat.strb = trn.rem[0] ? strb_full : strb_half;
    beat.last = trn.eof;

    // ----------------------------------------------------------
    // Sideband
    // ----------------------------------------------------------
    // SOF always at byte 0 for this width
    beat.user.is_sof = {trn.sof, {(loc_w-1){1'b0}}};

    // Enable, hardwired 0, dword of EOF, then byte 3 of that dword
    beat.user.is_eof = {trn.eof,
                        1'b0,
                        trn.rem,
                        eof_hw_low};

    beat.user.rsvd     = 2'b00;        // Unused
    beat.user.bar_hit  = trn.bar_hit;
    beat.user.err_fwd  = trn.errfwd;   // Poisoned TLP
    beat.user.ecrc_err = trn.ecrc_err;
  end

endmodule

`default_nettype wire

// ==== rx_axi_pkg.sv ====
/*
 * Receive interface definitions
 * Widths of the 64-bit TRN and AXI-Stream receive paths, the packed
 * beat structs on both sides and the 22-bit user sideband.
 */

`default_nettype none

package rx_axi_pkg;

  localparam int data_w  = 64;
  localparam int strb_w  = data_w / 8;  // 8
  localparam int rem_w   = 1;
  localparam int bar_w   = 8;
  localparam int dword_w = 32;
  localparam int loc_w   = 5;           // is_sof / is_eof width

  // Strobe values from rem
  localparam logic [strb_w-1:0] strb_full = {strb_w{1'b1}};
  localparam logic [strb_w-1:0] strb_half = {{(strb_w/2){1'b0}}, {(strb_w/2){1'b1}}};

  // is_eof bits 1:0 always set
  localparam logic [1:0] eof_hw_low = 2'b11;

  // ----------------------------------------------------------
  // TRN side beat
  // ----------------------------------------------------------
  typedef struct packed {
    logic [data_w-1:0] data;      // DW0 in upper half
    logic              sof;
    logic              eof;
    logic [rem_w-1:0]  rem;       // 1 = both dwords valid
    logic [bar_w-1:0]  bar_hit;
    logic              errfwd;
    logic              ecrc_err;
  } trn_beat_t;

  // ----------------------------------------------------------
  // AXI side beat and tuser layout
  // ----------------------------------------------------------
  typedef struct packed {
    logic [loc_w-1:0] is_eof;   // [21:17]
    logic [1:0]       rsvd;     // [16:15]
    logic [loc_w-1:0] is_sof;   // [14:10]
    logic [bar_w-1:0] bar_hit;  // [9:2]
    logic             err_fwd;  // [1]
    logic             ecrc_err; // [0]
  } rx_user_t;

  typedef struct packed {
    logic [data_w-1:0] data;
    logic [strb_w-1:0] strb;
    logic              last;
    rx_user_t          user;
  } axi_beat_t;

endpackage

`default_nettype wire

// ==== pcie_tlp_pkg.sv ====
/*
 * PCIe TLP header definitions
 * Format and type field positions in the first raw TRN beat,
 * format/type encodings and the MSI detector states.
 */

`default_nettype none

package pcie_tlp_pkg;

  // Field positions in raw (unswapped) first beat
  localparam int hdr_fmt_lsb  = 61;  // fmt at [62:61]
  localparam int hdr_fmt_w    = 2;
  localparam int hdr_type_lsb = 56;  // type at [60:56]
  localparam int hdr_type_w   = 5;

  localparam int msi_addr_w = 64;

  typedef enum logic [hdr_fmt_w-1:0] {
    fmt_3dw_nodata = 2'b00,
    fmt_4dw_nodata = 2'b01,
    fmt_3dw_data   = 2'b10,  // e.g. MWr 32-bit addr
    fmt_4dw_data   = 2'b11   // MWr 64-bit addr
  } tlp_fmt_e;

  typedef enum logic [hdr_type_w-1:0] {
    type_mem    = 5'b00000,
    type_mem_lk = 5'b00001,
    type_io     = 5'b00010,
    type_cfg0   = 5'b00100,
    type_cpl    = 5'b01010
  } tlp_type_e;

  // MSI address tracking
  typedef enum logic [1:0] {
    msi_idle   = 2'b00,
    msi_addr32 = 2'b01,  // next beat carries 32-bit address
    msi_addr64 = 2'b10   // next beat carries 64-bit address
  } msi_state_e;

endpackage

`default_nettype wire
